// File: hw/xbus_defines.svh
// Width, bank and timing constants for the Xbus main-memory slave.
// Included by the package and by every module that sizes ports or arrays.
`ifndef XBUS_DEFINES_SVH
`define XBUS_DEFINES_SVH

// Bus widths
`define XBUS_ADDR_W        22
`define XBUS_DATA_W        32

// Bank organization, words interleaved on the low address bits
`define XBUS_NUM_BANKS     4
`define XBUS_BANK_SEL_W    2
`define XBUS_BANK_WORDS    1024
`define XBUS_BANK_OFS_W    10

// Populated words, everything above is hole or undecoded
`define XBUS_RAM_WORDS     (`XBUS_NUM_BANKS * `XBUS_BANK_WORDS)

// Slow-memory acknowledge line, stages after req_delayed
`define XBUS_ACK_DELAY     7

// First address that is not decoded at all
`define XBUS_DECODE_LIMIT  22'o11000000

`endif

// File: hw/xbus_pkg.sv
// Shared types for the Xbus memory slave.
// Modules pull these in with a wildcard import in their header.
`default_nettype none

`include "xbus_defines.svh"

package xbus_pkg;

   // Word address on the Xbus
   typedef logic [`XBUS_ADDR_W-1:0] xbus_addr_t;

   // One full data word, no byte lanes
   typedef logic [`XBUS_DATA_W-1:0] xbus_word_t;

   // Word offset inside one bank
   typedef logic [`XBUS_BANK_OFS_W-1:0] xbus_bank_ofs_t;

   // Bank index from the low address bits
   typedef logic [`XBUS_BANK_SEL_W-1:0] xbus_bank_sel_t;

   // Result of the address decode
   typedef enum logic [1:0] {
      kind_ram,   // Populated, goes to a bank
      kind_hole,  // Decoded but empty
      kind_miss   // At or above the decode limit
   } xbus_kind_t;

endpackage

`default_nettype wire

// File: hw/xbus_if.sv
// Request and response signals between the front end, one RAM bank and
// the response collector. One instance per bank.
`timescale 1ns/1ps
`default_nettype none

interface xbus_if
   import xbus_pkg::*;
;

   logic           req;      // One-cycle request pulse
   logic           write;
   xbus_bank_ofs_t ofs;
   xbus_word_t     datain;
   xbus_word_t     dataout;
   logic           ack;      // One-cycle acknowledge pulse

   modport front (
      output req,
      output write,
      output ofs,
      output datain
   );

   modport bank (
      input  req,
      input  write,
      input  ofs,
      input  datain,
      output dataout,
      output ack
   );

   modport collect (
      input  dataout,
      input  ack
   );

endinterface

`default_nettype wire

// File: hw/xbus_wb_front.sv
// Wishbone classic front end of the memory slave. Decodes the address,
// sends RAM requests to a bank, hole requests to the collector, errors back.
`timescale 1ns/1ps
`default_nettype none

`include "xbus_defines.svh"

module xbus_wb_front
   import xbus_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       wb_cyc,
   input  logic       wb_stb,
   input  logic       wb_we,
   input  xbus_addr_t wb_adr,
   input  xbus_word_t wb_dat_w,
   output logic       wb_err,
   input  logic       done,
   output logic       hole_req,
   output logic       hole_write,
   xbus_if.front      banks [`XBUS_NUM_BANKS]
);

   logic                       busy;
   logic                       accept;
   xbus_kind_t                 kind;
   xbus_bank_sel_t             bank_sel;
   xbus_bank_ofs_t             bank_ofs;
   logic                       miss_q;
   logic [`XBUS_NUM_BANKS-1:0] bank_req_q;
   logic                       write_q;
   xbus_bank_ofs_t             ofs_q;
   xbus_word_t                 data_q;

   // Three-way split of the address space
   always_comb
   begin
      if (wb_adr < xbus_addr_t'(`XBUS_RAM_WORDS))
      begin
         kind = kind_ram;
      end
      else if (wb_adr < `XBUS_DECODE_LIMIT)
      begin
         kind = kind_hole;
      end
      else
      begin
         kind = kind_miss;
      end
   end

   assign bank_sel = wb_adr[`XBUS_BANK_SEL_W-1:0];                   // Interleave
   assign bank_ofs = wb_adr[`XBUS_BANK_SEL_W +: `XBUS_BANK_OFS_W];

   // Only one transfer in flight
   assign accept = wb_cyc & wb_stb & ~busy;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy       <= 1'b0;
         bank_req_q <= '0;
         hole_req   <= 1'b0;
         miss_q     <= 1'b0;
         wb_err     <= 1'b0;
      end
      else
      begin
         bank_req_q <= '0;                    // Pulses by default
         hole_req   <= 1'b0;
         miss_q     <= 1'b0;
         wb_err     <= miss_q;                // Error one cycle after the decode
         if (accept)
         begin
            busy <= 1'b1;
            case (kind)
               kind_ram:  bank_req_q[bank_sel] <= 1'b1;
               kind_hole: hole_req <= 1'b1;
               default:   miss_q <= 1'b1;
            endcase
         end
         else if (done || wb_err)
         begin
            busy <= 1'b0;                     // Idle again on the next edge
         end
      end
   end

   // Request payload, held until the next accepted transfer
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         write_q <= wb_we;
         ofs_q   <= bank_ofs;
         data_q  <= wb_dat_w;
      end
   end

   assign hole_write = write_q;

   for (genvar b = 0; b < `XBUS_NUM_BANKS; b++)
   begin : g_bank
      assign banks[b].req    = bank_req_q[b];
      assign banks[b].write  = write_q;
      assign banks[b].ofs    = ofs_q;
      assign banks[b].datain = data_q;
   end

endmodule

`default_nettype wire

// File: hw/xbus_ram_bank.sv
// One slow RAM bank. Takes a request only while its acknowledge line is
// empty, writes on acceptance and acknowledges a fixed time later.
`timescale 1ns/1ps
`default_nettype none

`include "xbus_defines.svh"

module xbus_ram_bank
   import xbus_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   xbus_if.bank  bus
);

   xbus_word_t                 mem [`XBUS_BANK_WORDS];
   logic                       req_delayed;
   logic [`XBUS_ACK_DELAY-1:0] ack_delayed;
   logic                       line_busy;
   logic                       accept;
   xbus_bank_ofs_t             ofs_q;

   // Memory starts out zeroed
   initial
   begin
      for (int i = 0; i < `XBUS_BANK_WORDS; i++)
      begin
         mem[i] = '0;
      end
   end

   assign line_busy = req_delayed | (|ack_delayed);
   assign accept    = bus.req & ~line_busy;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         req_delayed <= 1'b0;
         ack_delayed <= '0;
      end
      else
      begin
         req_delayed <= accept;
         ack_delayed <= {ack_delayed[`XBUS_ACK_DELAY-2:0], req_delayed};  // Shift
      end
   end

   // Write port and held read offset
   always @(posedge clk)
   begin
      if (accept)
      begin
         ofs_q <= bus.ofs;
         if (bus.write)
         begin
            mem[bus.ofs] <= bus.datain;
         end
      end
   end

   assign bus.dataout = mem[ofs_q];                 // Stable until the next request
   assign bus.ack     = ack_delayed[`XBUS_ACK_DELAY-1];

endmodule

`default_nettype wire

// File: hw/xbus_resp_collect.sv
// Collects bank acknowledges and read data, plus the hole responses, and
// drives the Wishbone return path.
`timescale 1ns/1ps
`default_nettype none

`include "xbus_defines.svh"

module xbus_resp_collect
   import xbus_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   xbus_if.collect    banks [`XBUS_NUM_BANKS],
   input  logic       hole_req,
   input  logic       hole_write,
   output xbus_word_t wb_dat_r,
   output logic       wb_ack,
   output logic       done
);

   // Matches the bank path: req_delayed, the ack line and the output flop
   localparam int HOLE_DELAY = `XBUS_ACK_DELAY + 2;

   logic [`XBUS_NUM_BANKS-1:0] bank_ack;
   xbus_word_t                 bank_data [`XBUS_NUM_BANKS];
   xbus_bank_sel_t             ack_sel;
   logic                       ack_q;
   xbus_word_t                 dat_q;
   logic [HOLE_DELAY-1:0]      hole_dly;
   logic                       hole_wr_q;

   for (genvar b = 0; b < `XBUS_NUM_BANKS; b++)
   begin : g_bank
      assign bank_ack[b]  = banks[b].ack;
      assign bank_data[b] = banks[b].dataout;
   end

   // At most one bank acknowledges at a time
   always_comb
   begin
      ack_sel = '0;
      for (int b = 0; b < `XBUS_NUM_BANKS; b++)
      begin
         if (bank_ack[b])
         begin
            ack_sel = xbus_bank_sel_t'(b);
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack_q    <= 1'b0;
         hole_dly <= '0;
      end
      else
      begin
         ack_q    <= |bank_ack;
         hole_dly <= {hole_dly[HOLE_DELAY-2:0], hole_req};
      end
   end

   always_ff @(posedge clk)
   begin
      dat_q <= bank_data[ack_sel];
      if (hole_req)
      begin
         hole_wr_q <= hole_write;
      end
   end

   assign wb_ack   = ack_q | hole_dly[HOLE_DELAY-1];
   assign wb_dat_r = hole_dly[HOLE_DELAY-1] ? (hole_wr_q ? '0 : '1) : dat_q;  // Hole reads all ones
   assign done     = wb_ack;

endmodule

`default_nettype wire

// File: hw/xbus_memory_top.sv
// Xbus main-memory slave with a Wishbone classic port. Connect a single
// Wishbone master; four interleaved banks sit behind the front end.
`timescale 1ns/1ps
`default_nettype none

`include "xbus_defines.svh"

module xbus_memory_top
   import xbus_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       wb_cyc,
   input  logic       wb_stb,
   input  logic       wb_we,
   input  xbus_addr_t wb_adr,
   input  xbus_word_t wb_dat_w,
   output xbus_word_t wb_dat_r,
   output logic       wb_ack,
   output logic       wb_err
);

   logic done;
   logic hole_req;
   logic hole_write;

   xbus_if bank_bus [`XBUS_NUM_BANKS] ();

   xbus_wb_front front0 (
      .clk        (clk),
      .reset      (reset),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_err     (wb_err),
      .done       (done),
      .hole_req   (hole_req),
      .hole_write (hole_write),
      .banks      (bank_bus)
   );

   for (genvar b = 0; b < `XBUS_NUM_BANKS; b++)
   begin : g_bank
      xbus_ram_bank bank0 (
         .clk   (clk),
         .reset (reset),
         .bus   (bank_bus[b])
      );
   end

   xbus_resp_collect collect0 (
      .clk        (clk),
      .reset      (reset),
      .banks      (bank_bus),
      .hole_req   (hole_req),
      .hole_write (hole_write),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .done       (done)
   );

endmodule

`default_nettype wire

// File: bench/xbus_memory_tb.sv
// Testbench for the Xbus memory slave. Runs Wishbone transfers listed in
// bench/xbus_memory_tests.txt and checks data, ack, err and latency.
`timescale 1ns/1ps
`default_nettype none

`include "xbus_defines.svh"

module xbus_memory_tb;

   localparam int CLK_HALF        = 50;
   localparam int RESET_CYCLES    = 8;
   localparam int ACK_LATENCY     = 10;   // Cycle after E0 + 9
   localparam int ERR_LATENCY     = 2;    // Cycle after E0 + 1
   localparam int MAX_WAIT        = 16;
   localparam int WATCHDOG_CYCLES = 20;

   logic                    clk;
   logic                    reset;
   logic                    wb_cyc;
   logic                    wb_stb;
   logic                    wb_we;
   logic [`XBUS_ADDR_W-1:0] wb_adr;
   logic [31:0]             wb_dat_w;
   logic [31:0]             wb_dat_r;
   logic                    wb_ack;
   logic                    wb_err;

   string       t_name [$];
   string       t_op [$];
   string       t_adr [$];
   string       t_wdat [$];
   string       t_exp [$];
   logic [31:0] shadow [`XBUS_RAM_WORDS];   // Expected RAM contents
   logic [31:0] rand_state;
   int          pass_count;
   int          fail_count;
   logic        tests_loaded;

   xbus_memory_top dut0 (
      .clk      (clk),
      .reset    (reset),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .wb_err   (wb_err)
   );

   always
   begin
      #(CLK_HALF) clk = ~clk;
   end

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Comment lines start with '#'
   task automatic load_tests();
      int    fd;
      int    n;
      string line;
      string name;
      string op;
      string adr;
      string wdat;
      string expv;
      fd = $fopen("bench/xbus_memory_tests.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the test file bench/xbus_memory_tests.txt");
         return;
      end
      while (!$feof(fd))
      begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line.getc(0) != "#")
         begin
            n = $sscanf(line, "%s %s %s %s %s", name, op, adr, wdat, expv);
            if (n == 5)
            begin
               t_name.push_back(name);
               t_op.push_back(op);
               t_adr.push_back(adr);
               t_wdat.push_back(wdat);
               t_exp.push_back(expv);
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic run_test(input int idx);
      string       name;
      logic [31:0] adr;
      logic [31:0] wdat;
      logic [31:0] exp_val;
      logic [31:0] dat_seen;
      int          cycles;
      int          rc;
      logic        got;
      logic        ack_seen;
      logic        err_seen;
      logic        ok;
      logic        is_write;
      logic        in_ram;
      name     = t_name[idx];
      rc       = $sscanf(t_adr[idx], "%h", adr);
      is_write = (t_op[idx] == "wr");
      in_ram   = (adr < `XBUS_RAM_WORDS);
      wdat     = '0;
      if (t_wdat[idx] == "rand")
      begin
         rand_state = next_random(rand_state);
         wdat       = rand_state;
      end
      else if (t_wdat[idx] != "-")
      begin
         rc = $sscanf(t_wdat[idx], "%h", wdat);
      end

      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = is_write;
      wb_adr   = adr[`XBUS_ADDR_W-1:0];
      wb_dat_w = wdat;

      // Count cycles from E0 until the first ack or err
      cycles = 0;
      got    = 1'b0;
      while (!got && cycles < MAX_WAIT)
      begin
         @(negedge clk);
         cycles++;
         if (wb_ack || wb_err)
         begin
            got = 1'b1;
         end
      end
      ack_seen = wb_ack;
      err_seen = wb_err;
      dat_seen = wb_dat_r;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;

      ok = 1'b1;
      if (!got)
      begin
         $display("%s: no ack or err came back within %0d cycles", name, MAX_WAIT);
         ok = 1'b0;
      end
      else if (t_exp[idx] == "err")
      begin
         if (err_seen !== 1'b1)
         begin
            $display("[ERROR] %s err: expected 1, actual %b", name, err_seen);
            ok = 1'b0;
         end
         if (ack_seen !== 1'b0)
         begin
            $display("[ERROR] %s ack: expected 0, actual %b", name, ack_seen);
            ok = 1'b0;
         end
         if (cycles != ERR_LATENCY)
         begin
            $display("[ERROR] %s latency: expected %0d, actual %0d", name, ERR_LATENCY, cycles);
            ok = 1'b0;
         end
      end
      else
      begin
         if (ack_seen !== 1'b1 || err_seen !== 1'b0)
         begin
            $display("[ERROR] %s ack/err: expected 1/0, actual %b/%b", name, ack_seen, err_seen);
            ok = 1'b0;
         end
         if (cycles != ACK_LATENCY)
         begin
            $display("[ERROR] %s latency: expected %0d, actual %0d", name, ACK_LATENCY, cycles);
            ok = 1'b0;
         end
         if (!is_write)
         begin
            exp_val = '0;
            if (t_exp[idx] == "rand")
            begin
               exp_val = in_ram ? shadow[adr[11:0]] : 32'hffff_ffff;
            end
            else
            begin
               rc = $sscanf(t_exp[idx], "%h", exp_val);
            end
            if (dat_seen !== exp_val)
            begin
               $display("[ERROR] %s data: expected %h, actual %h", name, exp_val, dat_seen);
               ok = 1'b0;
            end
         end
      end

      // Ack and err are one-cycle pulses
      @(negedge clk);
      if (got && (wb_ack || wb_err))
      begin
         $display("%s: ack or err stayed high for more than one cycle", name);
         ok = 1'b0;
      end

      if (is_write && in_ram)
      begin
         shadow[adr[11:0]] = wdat;
      end

      if (ok)
      begin
         pass_count++;
         $display("PASS %s", name);
      end
      else
      begin
         fail_count++;
         $display("FAIL %s", name);
      end
   endtask

   initial
   begin
      clk          = 1'b0;
      reset        = 1'b1;
      wb_cyc       = 1'b0;
      wb_stb       = 1'b0;
      wb_we        = 1'b0;
      wb_adr       = '0;
      wb_dat_w     = '0;
      pass_count   = 0;
      fail_count   = 0;
      tests_loaded = 1'b0;
      rand_state   = 32'ha708;
      for (int i = 0; i < `XBUS_RAM_WORDS; i++)
      begin
         shadow[i] = '0;
      end
      load_tests();
      tests_loaded = 1'b1;

      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      if (t_name.size() == 0)
      begin
         $display("No tests were found in the test file");
         fail_count++;
      end
      for (int i = 0; i < t_name.size(); i++)
      begin
         run_test(i);
      end

      $display("Tests done: %0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0)
      begin
         $display("Verification passed");
      end
      else
      begin
         $display("Verification failed");
      end
      $finish;
   end

   // Watchdog sized from the number of test lines
   initial
   begin
      int timeout_ns;
      wait (tests_loaded);
      timeout_ns = ((t_name.size() + 1) * WATCHDOG_CYCLES + RESET_CYCLES) * 2 * CLK_HALF;
      #(timeout_ns);
      $display("Timeout: the tests did not finish within %0d ns", timeout_ns);
      $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: xbus_memory_top.f
+incdir+hw
hw/xbus_pkg.sv
hw/xbus_if.sv
hw/xbus_wb_front.sv
hw/xbus_ram_bank.sv
hw/xbus_resp_collect.sv
hw/xbus_memory_top.sv
bench/xbus_memory_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the Xbus memory testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing \
   -f xbus_memory_top.f \
   --top-module xbus_memory_tb \
   -o xbus_memory_sim

./obj_dir/xbus_memory_sim | tee "$LOG"

if grep -q "Verification passed" "$LOG"; then
   echo "Simulation result: PASS"
   exit 0
else
   echo "Simulation result: FAIL"
   exit 1
fi

// File: bench/xbus_memory_tests.txt
# Columns: name op(rd/wr) addr(hex) wdata(hex, rand or -) expect(hex, rand, ack or err)
# rand as expect means the value last written there, hole reads give ffffffff
rd_zero_0 rd 000000 - 00000000
rd_zero_1 rd 000001 - 00000000
rd_zero_2 rd 000002 - 00000000
rd_zero_3 rd 000003 - 00000000
rd_zero_top rd 000fff - 00000000
wr_b0 wr 000010 11111111 ack
wr_b1 wr 000011 22222222 ack
wr_b2 wr 000012 33333333 ack
wr_b3 wr 000013 44444444 ack
rd_b0 rd 000010 - 11111111
rd_b1 rd 000011 - 22222222
rd_b2 rd 000012 - 33333333
rd_b3 rd 000013 - 44444444
rd_next_row rd 000014 - 00000000
wr_rand_a wr 000123 rand ack
wr_rand_b wr 000124 rand ack
wr_rand_c wr 000ffe rand ack
rd_rand_a rd 000123 - rand
rd_rand_b rd 000124 - rand
rd_rand_c rd 000ffe - rand
wr_over_1 wr 000200 aaaa5555 ack
wr_over_2 wr 000200 rand ack
rd_over rd 000200 - rand
rd_b0_again rd 000010 - 11111111
rd_hole_low rd 001000 - ffffffff
rd_hole_mid rd 100000 - ffffffff
rd_hole_high rd 23ffff - ffffffff
wr_hole wr 001000 deadbeef ack
rd_hole_after_wr rd 001000 - ffffffff
rd_alias_0 rd 000000 - rand
wr_hole_alias wr 001010 cafef00d ack
rd_alias_10 rd 000010 - 11111111
miss_limit rd 240000 - err
miss_limit_wr wr 240000 12345678 err
miss_top rd 3fffff - err
rd_after_miss rd 000011 - 22222222
wr_after_miss wr 000013 rand ack
rd_after_miss_b3 rd 000013 - rand
